/* rtl/tiny_core_pkg.sv */
/*
 * Shared definitions of the tiny in-order core
 * - data, address and register index widths
 * - reset PC value
 * - opcode encoding of the 32-bit instruction format
 * - payload structs passed between the pipeline stages
 */
package tiny_core_pkg;

    localparam int unsigned XLEN          = 32;
    localparam int unsigned NUM_REGS      = 16;
    localparam int unsigned REG_ADDR_BITS = 4;

    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0000;

    // Bits 31..28 of the instruction word, other codes are no-ops
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LUI  = 4'h6,
        OP_BEQ  = 4'h7,
        OP_BNE  = 4'h8,
        OP_JAL  = 4'h9
    } opcode_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_entry_t;

    // Decoded instruction with its operands read
    typedef struct packed {
        opcode_e                  op;
        logic [REG_ADDR_BITS-1:0] rd;
        logic                     rd_we;
        logic [XLEN-1:0]          op_a;
        logic [XLEN-1:0]          op_b;
        logic [XLEN-1:0]          imm;
        logic [XLEN-1:0]          pc;
    } issue_pkt_t;

    typedef struct packed {
        logic                     valid;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [XLEN-1:0]          data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

/* rtl/fetch_issue_if.sv */
/*
 * Fetch to issue channel
 * - valid/ready handshake carrying one fetch entry
 * - flush line that empties both sides
 */
`timescale 1ns/1ps

interface fetch_issue_if;

    logic                        valid;
    logic                        ready;
    tiny_core_pkg::fetch_entry_t entry;
    logic                        flush;

    modport fetch (output valid, output entry, input ready, input flush);

    modport issue (output ready, input valid, input entry, input flush);

endinterface

/* rtl/pc_gen.sv */
/*
 * Next fetch address generator
 * - boots from the reset PC
 * - steps by one word per accepted request
 * - loads the target of a resolved branch or jump
 */
`timescale 1ns/1ps

module pc_gen (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          fetch_enable_i,
    input  logic                          addr_ack_i,
    input  tiny_core_pkg::redirect_t      redirect_i,
    output logic [tiny_core_pkg::XLEN-1:0] fetch_addr_o,
    output logic                          fetch_valid_o
);

    logic [tiny_core_pkg::XLEN-1:0] addr_q;
    logic                           valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_q  <= tiny_core_pkg::BOOT_ADDR;
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_enable_i;
            // Redirect has priority over the sequential step
            if (redirect_i.valid) begin
                addr_q <= redirect_i.target;
            end else if (addr_ack_i) begin
                addr_q <= addr_q + 32'd4;
            end
        end
    end

    assign fetch_addr_o  = addr_q;
    assign fetch_valid_o = valid_q;

endmodule

/* rtl/fetch_stage.sv */
/*
 * Instruction fetch stage
 * - request/grant/rvalid port to the instruction memory
 * - one ring of slots, allocated on grant and filled on response
 * - in-flight requests plus queued entries bounded by the depth
 * - flush drops queued entries and responses still due
 */
`timescale 1ns/1ps

module fetch_stage #(
    parameter int unsigned FETCH_QUEUE_DEPTH = 2
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [tiny_core_pkg::XLEN-1:0] fetch_addr_i,
    input  logic                           fetch_valid_i,
    output logic                           addr_ack_o,
    output logic                           instr_req_o,
    output logic [tiny_core_pkg::XLEN-1:0] instr_addr_o,
    input  logic                           instr_gnt_i,
    input  logic                           instr_rvalid_i,
    input  logic [tiny_core_pkg::XLEN-1:0] instr_rdata_i,
    fetch_issue_if.fetch                   fetch_o
);

    localparam int unsigned CNT_W = $clog2(FETCH_QUEUE_DEPTH + 1);
    localparam int unsigned PTR_W = (FETCH_QUEUE_DEPTH > 1) ? $clog2(FETCH_QUEUE_DEPTH) : 1;

    logic [tiny_core_pkg::XLEN-1:0] pc_q    [FETCH_QUEUE_DEPTH];
    logic [tiny_core_pkg::XLEN-1:0] instr_q [FETCH_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q, fill_ptr_q, rd_ptr_q;
    // Allocated slots, slots holding data, responses to throw away
    logic [CNT_W-1:0] total_cnt_q, filled_cnt_q, discard_cnt_q;
    logic [CNT_W-1:0] pending;
    logic [CNT_W:0]   inflight;
    logic             gnt_fire, resp_drop, resp_fill, pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(FETCH_QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + PTR_W'(1);
    endfunction

    // ----------------------------------------------------------
    // Memory side
    // ----------------------------------------------------------
    assign inflight = {1'b0, total_cnt_q} + {1'b0, discard_cnt_q};
    assign pending  = total_cnt_q - filled_cnt_q;

    // No new request in the flush cycle, the address is about to change
    assign instr_req_o  = fetch_valid_i && !fetch_o.flush
                          && (inflight < (CNT_W + 1)'(FETCH_QUEUE_DEPTH));
    assign instr_addr_o = fetch_addr_i;
    assign gnt_fire     = instr_req_o & instr_gnt_i;
    assign addr_ack_o   = gnt_fire;

    assign resp_drop = instr_rvalid_i && (discard_cnt_q != '0);
    assign resp_fill = instr_rvalid_i && (discard_cnt_q == '0);

    // ----------------------------------------------------------
    // Issue side
    // ----------------------------------------------------------
    assign fetch_o.valid       = (filled_cnt_q != '0);
    assign fetch_o.entry.pc    = pc_q[rd_ptr_q];
    assign fetch_o.entry.instr = instr_q[rd_ptr_q];
    assign pop                 = fetch_o.valid & fetch_o.ready & ~fetch_o.flush;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q      <= '0;
            fill_ptr_q    <= '0;
            rd_ptr_q      <= '0;
            total_cnt_q   <= '0;
            filled_cnt_q  <= '0;
            discard_cnt_q <= '0;
        end else if (fetch_o.flush) begin
            wr_ptr_q      <= '0;
            fill_ptr_q    <= '0;
            rd_ptr_q      <= '0;
            total_cnt_q   <= '0;
            filled_cnt_q  <= '0;
            // A response this cycle consumes either a discard or a pending slot
            discard_cnt_q <= discard_cnt_q + pending - CNT_W'(instr_rvalid_i);
        end else begin
            if (gnt_fire) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (resp_fill) begin
                fill_ptr_q <= next_ptr(fill_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            total_cnt_q   <= total_cnt_q + CNT_W'(gnt_fire) - CNT_W'(pop);
            filled_cnt_q  <= filled_cnt_q + CNT_W'(resp_fill) - CNT_W'(pop);
            discard_cnt_q <= discard_cnt_q - CNT_W'(resp_drop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (gnt_fire) begin
            pc_q[wr_ptr_q] <= fetch_addr_i;
        end
        if (resp_fill) begin
            instr_q[fill_ptr_q] <= instr_rdata_i;
        end
    end

endmodule

/* rtl/issue_stage.sv */
/*
 * Issue stage
 * - decode register fed from the fetch queue
 * - 16-entry register file with write-through reads
 * - busy-bit scoreboard for read-after-write stalls
 */
`timescale 1ns/1ps

module issue_stage (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    fetch_issue_if.issue              fetch_i,
    input  tiny_core_pkg::wb_t        wb_i,
    output logic                      issue_valid_o,
    output tiny_core_pkg::issue_pkt_t issue_pkt_o
);

    logic                                    dec_valid_q;
    tiny_core_pkg::fetch_entry_t             dec_entry_q;
    logic [tiny_core_pkg::NUM_REGS-1:0]      busy_q;
    logic [tiny_core_pkg::XLEN-1:0]          rf_q [tiny_core_pkg::NUM_REGS];

    tiny_core_pkg::opcode_e                  op;
    logic [tiny_core_pkg::REG_ADDR_BITS-1:0] rd, rs1, rs2;
    logic                                    rd_we, stall, issue_fire, accept;
    logic [tiny_core_pkg::NUM_REGS-1:0]      set_mask, clr_mask;

    // Register 0 reads zero, a same-cycle writeback is passed through
    function automatic logic [tiny_core_pkg::XLEN-1:0] read_reg(
        input logic [tiny_core_pkg::REG_ADDR_BITS-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end else if (wb_i.valid && wb_i.rd == idx) begin
            return wb_i.data;
        end
        return rf_q[idx];
    endfunction

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    always_comb begin
        op  = tiny_core_pkg::opcode_e'(dec_entry_q.instr[31:28]);
        rd  = dec_entry_q.instr[27:24];
        rs1 = dec_entry_q.instr[23:20];
        rs2 = dec_entry_q.instr[19:16];
        case (op)
            tiny_core_pkg::OP_ADD, tiny_core_pkg::OP_SUB, tiny_core_pkg::OP_AND,
            tiny_core_pkg::OP_OR, tiny_core_pkg::OP_XOR, tiny_core_pkg::OP_ADDI,
            tiny_core_pkg::OP_LUI, tiny_core_pkg::OP_JAL: rd_we = (rd != '0);
            default: rd_we = 1'b0;
        endcase
    end

    always_comb begin
        issue_pkt_o.op    = op;
        issue_pkt_o.rd    = rd;
        issue_pkt_o.rd_we = rd_we;
        issue_pkt_o.op_a  = read_reg(rs1);
        issue_pkt_o.op_b  = read_reg(rs2);
        issue_pkt_o.imm   = {{16{dec_entry_q.instr[15]}}, dec_entry_q.instr[15:0]};
        issue_pkt_o.pc    = dec_entry_q.pc;
    end

    // Busy bits stay set until the writeback edge
    assign stall         = busy_q[rs1] | busy_q[rs2];
    assign issue_fire    = dec_valid_q & ~stall & ~fetch_i.flush;
    assign issue_valid_o = issue_fire;

    assign fetch_i.ready = ~dec_valid_q | issue_fire;
    assign accept        = fetch_i.valid & fetch_i.ready & ~fetch_i.flush;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dec_valid_q <= 1'b0;
        end else if (fetch_i.flush) begin
            dec_valid_q <= 1'b0;
        end else if (accept) begin
            dec_valid_q <= 1'b1;
        end else if (issue_fire) begin
            dec_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_entry_q <= fetch_i.entry;
        end
    end

    // ----------------------------------------------------------
    // Scoreboard and register file
    // ----------------------------------------------------------
    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (issue_fire && rd_we) begin
            set_mask[rd] = 1'b1;
        end
        if (wb_i.valid) begin
            clr_mask[wb_i.rd] = 1'b1;
        end
    end

    // A new issue to the same rd wins over the clear
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= '0;
        end else begin
            busy_q <= (busy_q & ~clr_mask) | set_mask;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wb_i.valid && wb_i.rd != '0) begin
            rf_q[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

/* rtl/execute_stage.sv */
/*
 * Execute stage
 * - ALU for register and immediate forms
 * - branch and jump resolution
 * - registered writeback and redirect
 */
`timescale 1ns/1ps

module execute_stage (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      issue_valid_i,
    input  tiny_core_pkg::issue_pkt_t issue_pkt_i,
    output tiny_core_pkg::wb_t        wb_o,
    output tiny_core_pkg::redirect_t  redirect_o
);

    logic                                    taken;
    logic [tiny_core_pkg::XLEN-1:0]          result, target;
    logic                                    wb_valid_q, redirect_valid_q;
    logic [tiny_core_pkg::REG_ADDR_BITS-1:0] wb_rd_q;
    logic [tiny_core_pkg::XLEN-1:0]          wb_data_q, target_q;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (issue_pkt_i.op)
            tiny_core_pkg::OP_ADD:  result = issue_pkt_i.op_a + issue_pkt_i.op_b;
            tiny_core_pkg::OP_SUB:  result = issue_pkt_i.op_a - issue_pkt_i.op_b;
            tiny_core_pkg::OP_AND:  result = issue_pkt_i.op_a & issue_pkt_i.op_b;
            tiny_core_pkg::OP_OR:   result = issue_pkt_i.op_a | issue_pkt_i.op_b;
            tiny_core_pkg::OP_XOR:  result = issue_pkt_i.op_a ^ issue_pkt_i.op_b;
            tiny_core_pkg::OP_ADDI: result = issue_pkt_i.op_a + issue_pkt_i.imm;
            tiny_core_pkg::OP_LUI:  result = {issue_pkt_i.imm[15:0], 16'h0000};
            tiny_core_pkg::OP_BEQ:  taken  = (issue_pkt_i.op_a == issue_pkt_i.op_b);
            tiny_core_pkg::OP_BNE:  taken  = (issue_pkt_i.op_a != issue_pkt_i.op_b);
            tiny_core_pkg::OP_JAL: begin
                result = issue_pkt_i.pc + 32'd4;
                taken  = 1'b1;
            end
            default: ;
        endcase
    end

    // Word offset relative to the instruction's own PC
    assign target = issue_pkt_i.pc + {issue_pkt_i.imm[29:0], 2'b00};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wb_valid_q       <= 1'b0;
            redirect_valid_q <= 1'b0;
        end else begin
            wb_valid_q       <= issue_valid_i & issue_pkt_i.rd_we;
            redirect_valid_q <= issue_valid_i & taken;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            wb_rd_q   <= issue_pkt_i.rd;
            wb_data_q <= result;
            target_q  <= target;
        end
    end

    assign wb_o.valid        = wb_valid_q;
    assign wb_o.rd           = wb_rd_q;
    assign wb_o.data         = wb_data_q;
    assign redirect_o.valid  = redirect_valid_q;
    assign redirect_o.target = target_q;

endmodule

/* rtl/flush_ctrl.sv */
/*
 * Flush controller
 * - registered external fetch enable
 * - one-cycle fetch and issue flushes on a redirect
 */
`timescale 1ns/1ps

module flush_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     fetch_en_i,
    input  tiny_core_pkg::redirect_t redirect_i,
    output logic                     fetch_enable_o,
    output logic                     flush_fetch_o,
    output logic                     flush_issue_o
);

    logic fetch_enable_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fetch_enable_q <= 1'b0;
        end else begin
            fetch_enable_q <= fetch_en_i;
        end
    end

    assign fetch_enable_o = fetch_enable_q;

    // Everything younger than the branch sits in fetch or issue
    assign flush_fetch_o = redirect_i.valid;
    assign flush_issue_o = redirect_i.valid;

endmodule

/* rtl/tiny_core.sv */
/*
 * Tiny in-order core, top level
 * - PC generation, fetch, issue, execute and flush control
 * - instruction memory port and retirement port as plain signals
 */
`timescale 1ns/1ps

module tiny_core #(
    parameter int unsigned FETCH_QUEUE_DEPTH = 2
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        fetch_en_i,
    output logic        instr_req_o,
    output logic [31:0] instr_addr_o,
    input  logic        instr_gnt_i,
    input  logic        instr_rvalid_i,
    input  logic [31:0] instr_rdata_i,
    output logic        wb_valid_o,
    output logic [3:0]  wb_addr_o,
    output logic [31:0] wb_data_o
);

    // ----------------------------------------------------------
    // Stage to stage signals
    // ----------------------------------------------------------
    logic                           fetch_enable;
    logic [tiny_core_pkg::XLEN-1:0] fetch_addr;
    logic                           fetch_valid, addr_ack;
    logic                           flush_fetch, flush_issue;
    logic                           issue_valid;
    tiny_core_pkg::issue_pkt_t      issue_pkt;
    tiny_core_pkg::wb_t             wb;
    tiny_core_pkg::redirect_t       redirect;

    fetch_issue_if fetch_issue ();

    // Fetch queue and decode register share one flush line
    assign fetch_issue.flush = flush_fetch | flush_issue;

    flush_ctrl i_flush_ctrl (
        .clk_i          ( clk_i        ),
        .rst_ni         ( rst_ni       ),
        .fetch_en_i     ( fetch_en_i   ),
        .redirect_i     ( redirect     ),
        .fetch_enable_o ( fetch_enable ),
        .flush_fetch_o  ( flush_fetch  ),
        .flush_issue_o  ( flush_issue  )
    );

    pc_gen i_pc_gen (
        .clk_i          ( clk_i        ),
        .rst_ni         ( rst_ni       ),
        .fetch_enable_i ( fetch_enable ),
        .addr_ack_i     ( addr_ack     ),
        .redirect_i     ( redirect     ),
        .fetch_addr_o   ( fetch_addr   ),
        .fetch_valid_o  ( fetch_valid  )
    );

    fetch_stage #(
        .FETCH_QUEUE_DEPTH ( FETCH_QUEUE_DEPTH )
    ) i_fetch_stage (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .fetch_addr_i   ( fetch_addr     ),
        .fetch_valid_i  ( fetch_valid    ),
        .addr_ack_o     ( addr_ack       ),
        .instr_req_o    ( instr_req_o    ),
        .instr_addr_o   ( instr_addr_o   ),
        .instr_gnt_i    ( instr_gnt_i    ),
        .instr_rvalid_i ( instr_rvalid_i ),
        .instr_rdata_i  ( instr_rdata_i  ),
        .fetch_o        ( fetch_issue    )
    );

    issue_stage i_issue_stage (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .fetch_i       ( fetch_issue ),
        .wb_i          ( wb          ),
        .issue_valid_o ( issue_valid ),
        .issue_pkt_o   ( issue_pkt   )
    );

    execute_stage i_execute_stage (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .issue_valid_i ( issue_valid ),
        .issue_pkt_i   ( issue_pkt   ),
        .wb_o          ( wb          ),
        .redirect_o    ( redirect    )
    );

    // Retirement port
    assign wb_valid_o = wb.valid;
    assign wb_addr_o  = wb.rd;
    assign wb_data_o  = wb.data;

endmodule

/* sim/tb_tiny_core.sv */
/*
 * Testbench for the tiny in-order core
 * - clock, reset and fetch enable sequencing
 * - instruction memory model with random grant and response delays
 * - program table and retirement table in program order
 * - value check task and watchdog
 */
`timescale 1ns/1ps

module tb_tiny_core;

    localparam int unsigned MEM_WORDS = 64;
    localparam int unsigned NUM_EXP   = 20;
    localparam int unsigned WATCHDOG  = NUM_EXP * 40 + 200;

    logic        clk_i;
    logic        rst_ni;
    logic        fetch_en_i;
    logic        instr_req_o;
    logic [31:0] instr_addr_o;
    logic        instr_gnt_i;
    logic        instr_rvalid_i;
    logic [31:0] instr_rdata_i;
    logic        wb_valid_o;
    logic [3:0]  wb_addr_o;
    logic [31:0] wb_data_o;

    logic [31:0] mem [MEM_WORDS];
    // Register index in bits 35..32, written value in bits 31..0
    logic [35:0] exp_tbl [NUM_EXP];

    // Due cycle in bits 63..32, request address in bits 31..0
    logic [63:0] resp_q [$];
    logic [63:0] resp_head;
    int unsigned rand_word;
    int          cycle;
    int          gnt_wait;
    bit          first_req_seen;
    int          idx;

    tiny_core #(
        .FETCH_QUEUE_DEPTH ( 2 )
    ) DUT (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .fetch_en_i     ( fetch_en_i     ),
        .instr_req_o    ( instr_req_o    ),
        .instr_addr_o   ( instr_addr_o   ),
        .instr_gnt_i    ( instr_gnt_i    ),
        .instr_rvalid_i ( instr_rvalid_i ),
        .instr_rdata_i  ( instr_rdata_i  ),
        .wb_valid_o     ( wb_valid_o     ),
        .wb_addr_o      ( wb_addr_o      ),
        .wb_data_o      ( wb_data_o      )
    );

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s is 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_idle();
        expect_equal("instr_req_o", {31'b0, instr_req_o}, 32'h0);
        expect_equal("wb_valid_o", {31'b0, wb_valid_o}, 32'h0);
    endtask

    function automatic logic [31:0] encode_instr(input logic [3:0] op, input logic [3:0] rd,
                                                 input logic [3:0] rs1, input logic [3:0] rs2,
                                                 input logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    // Outside the table every word decodes as a no-op
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if ((addr >> 2) < MEM_WORDS) begin
            return mem[addr >> 2];
        end
        return {4'hf, addr[29:2]};
    endfunction

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {4'hf, 28'(i)};
        end
        // ALU forms, last one writes r0
        mem[0]  = encode_instr(tiny_core_pkg::OP_ADDI, 4'd1, 4'd0, 4'd0, 16'd5);
        mem[1]  = encode_instr(tiny_core_pkg::OP_ADDI, 4'd2, 4'd0, 4'd0, 16'hfffd);
        mem[2]  = encode_instr(tiny_core_pkg::OP_LUI, 4'd3, 4'd0, 4'd0, 16'h1234);
        mem[3]  = encode_instr(tiny_core_pkg::OP_ADD, 4'd4, 4'd1, 4'd2, 16'h0);
        mem[4]  = encode_instr(tiny_core_pkg::OP_SUB, 4'd5, 4'd1, 4'd2, 16'h0);
        mem[5]  = encode_instr(tiny_core_pkg::OP_AND, 4'd6, 4'd2, 4'd3, 16'h0);
        mem[6]  = encode_instr(tiny_core_pkg::OP_OR, 4'd7, 4'd3, 4'd1, 16'h0);
        mem[7]  = encode_instr(tiny_core_pkg::OP_XOR, 4'd8, 4'd7, 4'd2, 16'h0);
        mem[8]  = encode_instr(tiny_core_pkg::OP_ADDI, 4'd0, 4'd1, 4'd0, 16'd7);
        // Dependent chain
        mem[9]  = encode_instr(tiny_core_pkg::OP_ADDI, 4'd9, 4'd1, 4'd0, 16'd1);
        mem[10] = encode_instr(tiny_core_pkg::OP_ADD, 4'd9, 4'd9, 4'd9, 16'h0);
        mem[11] = encode_instr(tiny_core_pkg::OP_SUB, 4'd10, 4'd9, 4'd1, 16'h0);
        mem[12] = encode_instr(tiny_core_pkg::OP_XOR, 4'd10, 4'd10, 4'd9, 16'h0);
        mem[13] = encode_instr(tiny_core_pkg::OP_ADDI, 4'd10, 4'd10, 4'd0, 16'hffff);
        // Taken BEQ and JAL, each skipping two words
        mem[14] = encode_instr(tiny_core_pkg::OP_BEQ, 4'd0, 4'd4, 4'd4, 16'd3);
        mem[15] = encode_instr(tiny_core_pkg::OP_ADDI, 4'd11, 4'd0, 4'd0, 16'h111);
        mem[16] = encode_instr(tiny_core_pkg::OP_ADDI, 4'd12, 4'd0, 4'd0, 16'h222);
        mem[17] = encode_instr(tiny_core_pkg::OP_JAL, 4'd13, 4'd0, 4'd0, 16'd3);
        mem[18] = encode_instr(tiny_core_pkg::OP_ADDI, 4'd11, 4'd0, 4'd0, 16'h333);
        mem[19] = encode_instr(tiny_core_pkg::OP_ADDI, 4'd12, 4'd0, 4'd0, 16'h444);
        mem[20] = encode_instr(tiny_core_pkg::OP_ADDI, 4'd11, 4'd0, 4'd0, 16'h55);
        // Not-taken BNE, then a count-down loop
        mem[21] = encode_instr(tiny_core_pkg::OP_BNE, 4'd0, 4'd1, 4'd1, 16'd5);
        mem[22] = encode_instr(tiny_core_pkg::OP_ADDI, 4'd12, 4'd0, 4'd0, 16'd3);
        mem[23] = encode_instr(tiny_core_pkg::OP_ADDI, 4'd12, 4'd12, 4'd0, 16'hffff);
        mem[24] = encode_instr(tiny_core_pkg::OP_BNE, 4'd0, 4'd12, 4'd0, 16'hffff);
        mem[25] = encode_instr(tiny_core_pkg::OP_ADDI, 4'd14, 4'd12, 4'd0, 16'h77);
        mem[26] = encode_instr(tiny_core_pkg::OP_JAL, 4'd0, 4'd0, 4'd0, 16'd0);
    endtask

    task automatic load_expected();
        exp_tbl[0]  = {4'd1, 32'h0000_0005};
        exp_tbl[1]  = {4'd2, 32'hffff_fffd};
        exp_tbl[2]  = {4'd3, 32'h1234_0000};
        exp_tbl[3]  = {4'd4, 32'h0000_0002};
        exp_tbl[4]  = {4'd5, 32'h0000_0008};
        exp_tbl[5]  = {4'd6, 32'h1234_0000};
        exp_tbl[6]  = {4'd7, 32'h1234_0005};
        exp_tbl[7]  = {4'd8, 32'hedcb_fff8};
        exp_tbl[8]  = {4'd9, 32'h0000_0006};
        exp_tbl[9]  = {4'd9, 32'h0000_000c};
        exp_tbl[10] = {4'd10, 32'h0000_0007};
        exp_tbl[11] = {4'd10, 32'h0000_000b};
        exp_tbl[12] = {4'd10, 32'h0000_000a};
        exp_tbl[13] = {4'd13, 32'h0000_0048};
        exp_tbl[14] = {4'd11, 32'h0000_0055};
        exp_tbl[15] = {4'd12, 32'h0000_0003};
        exp_tbl[16] = {4'd12, 32'h0000_0002};
        exp_tbl[17] = {4'd12, 32'h0000_0001};
        exp_tbl[18] = {4'd12, 32'h0000_0000};
        exp_tbl[19] = {4'd14, 32'h0000_0077};
    endtask

    // ----------------------------------------------------------
    // Clock, memory model, watchdog
    // ----------------------------------------------------------
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Inputs settle 1 ns after the edge, so a grant given here is taken at the next edge
    initial begin
        rand_word      = $urandom(32'hbf30);
        instr_gnt_i    = 1'b0;
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        cycle          = 0;
        first_req_seen = 1'b0;
        gnt_wait       = $urandom % 4;
        forever begin
            @(posedge clk_i);
            #1;
            cycle++;
            instr_rvalid_i = 1'b0;
            instr_rdata_i  = '0;
            if (resp_q.size() > 0) begin
                resp_head = resp_q[0];
                if (int'(resp_head[63:32]) <= cycle) begin
                    resp_head      = resp_q.pop_front();
                    instr_rvalid_i = 1'b1;
                    instr_rdata_i  = mem_word(resp_head[31:0]);
                end
            end
            instr_gnt_i = 1'b0;
            if (rst_ni && instr_req_o) begin
                if (!first_req_seen) begin
                    first_req_seen = 1'b1;
                    expect_equal("instr_addr_o", instr_addr_o, 32'h0000_0000);
                end
                if (gnt_wait == 0) begin
                    instr_gnt_i = 1'b1;
                    rand_word   = $urandom % 3;
                    resp_q.push_back({32'(cycle + 1 + int'(rand_word)), instr_addr_o});
                    gnt_wait    = $urandom % 4;
                end else begin
                    gnt_wait--;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk_i);
        abort_run("Timeout: the core did not retire all expected writes in time");
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        rst_ni     = 1'b0;
        fetch_en_i = 1'b0;
        load_program();
        load_expected();

        repeat (5) begin
            @(posedge clk_i);
            #1;
            check_idle();
        end
        rst_ni = 1'b1;
        // Core stays quiet until enabled
        repeat (4) begin
            @(posedge clk_i);
            #1;
            check_idle();
        end
        fetch_en_i = 1'b1;

        for (idx = 0; idx < NUM_EXP; idx++) begin
            do begin
                @(negedge clk_i);
            end while (!wb_valid_o);
            expect_equal("wb_addr_o", {28'b0, wb_addr_o}, {28'b0, exp_tbl[idx][35:32]});
            expect_equal("wb_data_o", wb_data_o, exp_tbl[idx][31:0]);
        end

        // Program ends in a self loop with no writes
        repeat (40) begin
            @(negedge clk_i);
            if (wb_valid_o) begin
                abort_run($sformatf("Unexpected write to register %0d after the last one",
                                    wb_addr_o));
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* vlog.f */
rtl/tiny_core_pkg.sv
rtl/fetch_issue_if.sv
rtl/pc_gen.sv
rtl/fetch_stage.sv
rtl/issue_stage.sv
rtl/execute_stage.sv
rtl/flush_ctrl.sv
rtl/tiny_core.sv
sim/tb_tiny_core.sv

/* Bender.yml */
package:
  name: tiny_core

sources:
  - rtl/tiny_core_pkg.sv
  - rtl/fetch_issue_if.sv
  - rtl/pc_gen.sv
  - rtl/fetch_stage.sv
  - rtl/issue_stage.sv
  - rtl/execute_stage.sv
  - rtl/flush_ctrl.sv
  - rtl/tiny_core.sv
  - target: simulation
    files:
      - sim/tb_tiny_core.sv
